// File: bench/tb_clkgen.sv
////////////////////
// Clock and reset for the testbench. Period 20, reset held for
// three rising edges and released shortly after the third.
////////////////////
module tb_clkgen (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;
  end

  initial begin
    o_rst = 1'b1;
    repeat (3) @(posedge o_clk);
    #2;
    o_rst = 1'b0;
  end

endmodule

// File: bench/xdom_ctrl_tb.sv
////////////////////
// Directed testbench for the control register core. Each test drives
// the command ports and checks the register outputs and read-back.
////////////////////
`include "xdom_defines.svh"

module xdom_ctrl_tb;

  localparam int TIMEOUT_CYCLES = 2000;

  logic clk;
  logic rst;
  xdom_bus_pkg::cmd_req_t   dbg_req;
  xdom_bus_pkg::cmd_req_t   icm_req;
  xdom_bus_pkg::cmd_rsp_t   dbg_rsp;
  xdom_bus_pkg::cmd_rsp_t   icm_rsp;
  xdom_reg_pkg::chan_mask_t wvb_armed;
  logic [`XDOM_N_CHANNELS*`XDOM_TAP_W-1:0] adc_delay_tap;
  logic                     adc_spi_ack;
  logic [7:0]               adc_spi_rd_data;
  xdom_reg_pkg::trig_conf_t trig_bundle;
  xdom_reg_pkg::wvb_conf_t  wvb_conf;
  xdom_reg_pkg::chan_mask_t trig_run;
  xdom_reg_pkg::chan_mask_t wvb_arm;
  logic [2*`XDOM_N_CHANNELS-1:0] adc_delay_ce;
  logic [2*`XDOM_N_CHANNELS-1:0] adc_delay_inc;
  logic [2*`XDOM_N_CHANNELS-1:0] adc_bitslip;
  xdom_reg_pkg::chan_mask_t discr_bitslip;
  xdom_reg_pkg::chan_mask_t adc_io_reset;
  xdom_reg_pkg::chan_mask_t discr_io_reset;
  logic                     adc_spi_req;
  logic [5:0]               adc_spi_sel;
  logic [23:0]              adc_spi_wr_data;

  xdom_reg_pkg::tap_t taps [`XDOM_N_CHANNELS];
  integer seed = 32'h121e;
  int     value_errs = 0;
  int     other_errs = 0;
  int     cycles = 0;
  int     dbg_acks = 0;
  int     icm_acks = 0;
  int     dbg_ack_cycle = 0;
  int     icm_ack_cycle = 0;

  tb_clkgen u_clkgen (.o_clk(clk), .o_rst(rst));

  xdom_ctrl DUT (
    .clk(clk), .rst(rst),
    .i_dbg(dbg_req), .i_icm(icm_req), .o_dbg(dbg_rsp), .o_icm(icm_rsp),
    .i_wvb_armed(wvb_armed), .i_adc_delay_tap(adc_delay_tap),
    .i_adc_spi_ack(adc_spi_ack), .i_adc_spi_rd_data(adc_spi_rd_data),
    .o_trig_bundle(trig_bundle), .o_wvb_conf(wvb_conf),
    .o_trig_run(trig_run), .o_wvb_arm(wvb_arm),
    .o_adc_delay_ce(adc_delay_ce), .o_adc_delay_inc(adc_delay_inc),
    .o_adc_bitslip(adc_bitslip), .o_discr_bitslip(discr_bitslip),
    .o_adc_io_reset(adc_io_reset), .o_discr_io_reset(discr_io_reset),
    .o_adc_spi_req(adc_spi_req), .o_adc_spi_sel(adc_spi_sel),
    .o_adc_spi_wr_data(adc_spi_wr_data)
  );

  ////////////////////
  // Cycle count, timeout and acknowledge monitor
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: no result after %0d cycles, DUT stopped answering", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  always @(posedge clk) begin
    #1;
    if (dbg_rsp.ack) begin
      dbg_acks++;
      dbg_ack_cycle = cycles;
    end
    if (icm_rsp.ack) begin
      icm_acks++;
      icm_ack_cycle = cycles;
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("ERR %s: expected %h, actual %h", name, exp, act);
    value_errs++;
  endtask

  ////////////////////
  // Command port transactions, entered and left 2 units after an edge
  task automatic port_access(input bit to_icm, input bit wr, input xdom_bus_pkg::adr_t adr,
                             input xdom_bus_pkg::data_t wdata,
                             output xdom_bus_pkg::data_t rdata);
    xdom_bus_pkg::cmd_req_t req;
    bit got;
    req.wr_req  = wr;
    req.rd_req  = !wr;
    req.adr     = adr;
    req.wr_data = wdata;
    got = 1'b0;
    if (to_icm) icm_req = req;
    else dbg_req = req;
    while (!got) begin
      @(posedge clk);
      #1;
      got   = to_icm ? icm_rsp.ack : dbg_rsp.ack;
      rdata = to_icm ? icm_rsp.rd_data : dbg_rsp.rd_data;
    end
    #1;
    if (to_icm) icm_req = '0;
    else dbg_req = '0;
  endtask

  task automatic port_write(input bit to_icm, input xdom_bus_pkg::adr_t adr,
                            input xdom_bus_pkg::data_t wdata);
    xdom_bus_pkg::data_t unused;
    port_access(to_icm, 1'b1, adr, wdata, unused);
  endtask

  task automatic port_read(input bit to_icm, input xdom_bus_pkg::adr_t adr,
                           output xdom_bus_pkg::data_t rdata);
    port_access(to_icm, 1'b0, adr, 16'h0000, rdata);
  endtask

  task automatic check_io_pulses(input string name, input logic [47:0] exp_adc,
                                 input logic [23:0] exp_discr);
    if (adc_delay_ce !== exp_adc) report_mismatch({name, " ce"}, 64'(exp_adc), 64'(adc_delay_ce));
    if (adc_delay_inc !== exp_adc)
      report_mismatch({name, " inc"}, 64'(exp_adc), 64'(adc_delay_inc));
    if (adc_bitslip !== exp_adc)
      report_mismatch({name, " bitslip"}, 64'(exp_adc), 64'(adc_bitslip));
    if (discr_bitslip !== exp_discr)
      report_mismatch({name, " discr"}, 64'(exp_discr), 64'(discr_bitslip));
  endtask

  ////////////////////
  // Tests
  task automatic test_reset_version();
    xdom_bus_pkg::data_t rd;
    port_read(1'b0, `ADR_VERSION, rd);
    if (rd !== `XDOM_VERSION) report_mismatch("reset_version", 64'(`XDOM_VERSION), 64'(rd));
    port_read(1'b0, `ADR_ADC_IORST_LO, rd);
    if (rd !== 16'hFFFF) report_mismatch("reset_iorst_lo", 64'(16'hFFFF), 64'(rd));
    port_read(1'b1, `ADR_ADC_IORST_HI, rd);
    if (rd !== 16'h00FF) report_mismatch("reset_iorst_hi", 64'(16'h00FF), 64'(rd));
    if (adc_io_reset !== 24'hFF_FFFF)
      report_mismatch("reset_adc_iorst", 64'(24'hFF_FFFF), 64'(adc_io_reset));
    if (discr_io_reset !== 24'hFF_FFFF)
      report_mismatch("reset_discr_iorst", 64'(24'hFF_FFFF), 64'(discr_io_reset));
    if (adc_spi_sel !== 6'h00) report_mismatch("reset_spi_sel", 64'(0), 64'(adc_spi_sel));
    if (adc_spi_wr_data !== 24'h0)
      report_mismatch("reset_spi_wr_data", 64'(0), 64'(adc_spi_wr_data));
    if (adc_spi_req !== 1'b0) report_mismatch("reset_spi_req", 64'(0), 64'(adc_spi_req));
    if (trig_run !== 24'h0) report_mismatch("reset_trig_run", 64'(0), 64'(trig_run));
    if (wvb_arm !== 24'h0) report_mismatch("reset_wvb_arm", 64'(0), 64'(wvb_arm));
    check_io_pulses("reset_pulses", 48'h0, 24'h0);
  endtask

  task automatic test_config_roundtrip();
    xdom_bus_pkg::data_t val;
    xdom_bus_pkg::data_t rd;
    val = 16'($random(seed));
    port_write(1'b0, `ADR_TRIG_THR, val);
    port_read(1'b0, `ADR_TRIG_THR, rd);
    if (rd !== (val & 16'h0FFF)) report_mismatch("cfg_thr", 64'(val & 16'h0FFF), 64'(rd));
    if (trig_bundle.thresh !== val[11:0])
      report_mismatch("cfg_thr_bundle", 64'(val[11:0]), 64'(trig_bundle.thresh));
    val = 16'($random(seed));
    port_write(1'b1, `ADR_TRIG_CTRL, val);
    port_read(1'b1, `ADR_TRIG_CTRL, rd);
    if (rd !== (val & 16'h007F)) report_mismatch("cfg_ctrl", 64'(val & 16'h007F), 64'(rd));
    if ({trig_bundle.ext_en, trig_bundle.thresh_en, trig_bundle.discr_en,
         trig_bundle.discr_pol, trig_bundle.trig_lt, trig_bundle.trig_gt,
         trig_bundle.trig_et} !== val[6:0])
      report_mismatch("cfg_ctrl_bundle", 64'(val[6:0]), 64'(trig_bundle));
    val = 16'($random(seed));
    port_write(1'b0, `ADR_PRE_CONF, val);
    port_read(1'b0, `ADR_PRE_CONF, rd);
    if (rd !== (val & 16'h001F)) report_mismatch("cfg_pre", 64'(val & 16'h001F), 64'(rd));
    if (wvb_conf.pre_conf !== val[4:0])
      report_mismatch("cfg_pre_bundle", 64'(val[4:0]), 64'(wvb_conf.pre_conf));
    val = 16'($random(seed));
    port_write(1'b1, `ADR_POST_CONF, val);
    port_read(1'b0, `ADR_POST_CONF, rd);
    if (rd !== (val & 16'h00FF)) report_mismatch("cfg_post", 64'(val & 16'h00FF), 64'(rd));
    if (wvb_conf.post_conf !== val[7:0])
      report_mismatch("cfg_post_bundle", 64'(val[7:0]), 64'(wvb_conf.post_conf));
  endtask

  // The acknowledge cycle is also the one-shot cycle
  task automatic test_one_shots();
    logic [23:0] mask;
    xdom_bus_pkg::data_t rd;
    mask = 24'($random(seed));
    port_write(1'b1, `ADR_TRIG_RUN_LO, mask[15:0]);
    if (trig_run !== {8'h00, mask[15:0]})
      report_mismatch("one_shot_lo", 64'({8'h00, mask[15:0]}), 64'(trig_run));
    @(posedge clk);
    #2;
    if (trig_run !== 24'h0) report_mismatch("one_shot_lo_clear", 64'(0), 64'(trig_run));
    port_write(1'b0, `ADR_TRIG_RUN_HI, {8'h00, mask[23:16]});
    if (trig_run !== {mask[23:16], 16'h0000})
      report_mismatch("one_shot_hi", 64'({mask[23:16], 16'h0000}), 64'(trig_run));
    @(posedge clk);
    #2;
    if (trig_run !== 24'h0) report_mismatch("one_shot_hi_clear", 64'(0), 64'(trig_run));
    port_read(1'b0, `ADR_TRIG_RUN_LO, rd);
    if (rd !== 16'h0000) report_mismatch("one_shot_lo_read", 64'(0), 64'(rd));
    port_read(1'b1, `ADR_TRIG_RUN_HI, rd);
    if (rd !== 16'h0000) report_mismatch("one_shot_hi_read", 64'(0), 64'(rd));
  endtask

  // Channel 5 owns bits 10 and 11 of the two-lane outputs
  task automatic test_io_pulse_tap();
    xdom_bus_pkg::data_t rd;
    port_write(1'b0, `ADR_IO_SEL, 16'd5);
    port_write(1'b0, `ADR_IO_PULSE, 16'h0177);
    check_io_pulses("io_pulse_early", 48'h0, 24'h0);
    @(posedge clk);
    #2;
    check_io_pulses("io_pulse", 48'h0000_0000_0C00, 24'h00_0020);
    @(posedge clk);
    #2;
    check_io_pulses("io_pulse_clear", 48'h0, 24'h0);
    port_read(1'b1, `ADR_TAP, rd);
    if (rd !== {6'b0, taps[5]}) report_mismatch("io_tap", 64'({6'b0, taps[5]}), 64'(rd));
  endtask

  task automatic test_arbitration();
    xdom_bus_pkg::data_t d_dbg;
    xdom_bus_pkg::data_t d_icm;
    xdom_bus_pkg::data_t rd;
    int dbg_before;
    int icm_before;
    // Serving ICM last makes debug the winner of the next tie
    port_read(1'b1, `ADR_VERSION, rd);
    d_dbg = 16'($random(seed)) & 16'h0FFF;
    d_icm = 16'($random(seed));
    dbg_before = dbg_acks;
    icm_before = icm_acks;
    fork
      port_write(1'b0, `ADR_CNST_CONF, d_dbg);
      port_write(1'b1, `ADR_ADC_SPI_WD_LO, d_icm);
    join
    // A stretched acknowledge would show in the cycle after the last one
    @(posedge clk);
    #2;
    if (dbg_acks - dbg_before !== 1)
      report_mismatch("arb_dbg_acks", 64'(1), 64'(dbg_acks - dbg_before));
    if (icm_acks - icm_before !== 1)
      report_mismatch("arb_icm_acks", 64'(1), 64'(icm_acks - icm_before));
    if (dbg_ack_cycle >= icm_ack_cycle) begin
      $display("Arbitration: ICM port was acknowledged before the debug port on a tie");
      other_errs++;
    end
    port_read(1'b1, `ADR_CNST_CONF, rd);
    if (rd !== d_dbg) report_mismatch("arb_dbg_data", 64'(d_dbg), 64'(rd));
    port_read(1'b1, `ADR_ADC_SPI_WD_LO, rd);
    if (rd !== d_icm) report_mismatch("arb_icm_data", 64'(d_icm), 64'(rd));
    if (adc_spi_wr_data[15:0] !== d_icm)
      report_mismatch("arb_icm_output", 64'(d_icm), 64'(adc_spi_wr_data[15:0]));
  endtask

  task automatic test_serial_task();
    xdom_bus_pkg::data_t rd;
    port_write(1'b0, `ADR_ADC_SPI_TASK, 16'h0001);
    if (adc_spi_req !== 1'b1) report_mismatch("spi_req_set", 64'(1), 64'(adc_spi_req));
    port_read(1'b0, `ADR_ADC_SPI_TASK, rd);
    if (rd !== 16'h0001) report_mismatch("spi_task_busy", 64'(1), 64'(rd));
    adc_spi_ack = 1'b1;
    @(posedge clk);
    #2;
    adc_spi_ack = 1'b0;
    if (adc_spi_req !== 1'b0) report_mismatch("spi_req_clear", 64'(0), 64'(adc_spi_req));
    port_read(1'b1, `ADR_ADC_SPI_TASK, rd);
    if (rd !== 16'h0000) report_mismatch("spi_task_done", 64'(0), 64'(rd));
  endtask

  ////////////////////
  // Main sequence
  initial begin
    dbg_req         = '0;
    icm_req         = '0;
    wvb_armed       = 24'hA5_3C_96;
    adc_spi_ack     = 1'b0;
    adc_spi_rd_data = 8'h5A;
    for (int i = 0; i < `XDOM_N_CHANNELS; i++) begin
      taps[i] = 10'($random(seed));
      adc_delay_tap[i*`XDOM_TAP_W +: `XDOM_TAP_W] = taps[i];
    end
    @(negedge rst);
    test_reset_version();
    test_config_roundtrip();
    test_one_shots();
    test_io_pulse_tap();
    test_arbitration();
    test_serial_task();
    $display("Value mismatches: %0d, other failures: %0d", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log for failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module xdom_ctrl_tb -f xdom_ctrl.f -o xdom_ctrl_sim \
  && ./obj_dir/xdom_ctrl_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
echo "Simulation finished without failure"
exit 0

// File: src/cmd_arbiter.sv
////////////////////
// Serves the debug and ICM command ports one at a time on the register
// bus. Ties alternate, debug first after reset.
////////////////////
module cmd_arbiter (
  input  logic                   clk,
  input  logic                   rst,
  input  xdom_bus_pkg::cmd_req_t i_dbg,
  input  xdom_bus_pkg::cmd_req_t i_icm,
  output xdom_bus_pkg::cmd_rsp_t o_dbg,
  output xdom_bus_pkg::cmd_rsp_t o_icm,
  output xdom_bus_pkg::reg_bus_t o_bus,
  input  xdom_bus_pkg::data_t    i_wvb_rd_data,
  input  logic                   i_wvb_hit,
  input  xdom_bus_pkg::data_t    i_io_rd_data,
  input  logic                   i_io_hit
);

  xdom_bus_pkg::arb_state_t state;
  xdom_bus_pkg::cmd_req_t   srv_req;
  xdom_bus_pkg::data_t      rd_q;
  logic                     dbg_pend;
  logic                     icm_pend;
  logic                     srv_icm;
  logic                     last_icm;

  assign dbg_pend = i_dbg.wr_req | i_dbg.rd_req;
  assign icm_pend = i_icm.wr_req | i_icm.rd_req;

  // Requester holds its fields until ack, so no copy is kept
  assign srv_req = srv_icm ? i_icm : i_dbg;

  ////////////////////
  // FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= xdom_bus_pkg::IDLE;
      srv_icm  <= 1'b0;
      // Debug wins the first tie
      last_icm <= 1'b1;
    end else begin
      case (state)
        xdom_bus_pkg::IDLE: begin
          if (dbg_pend || icm_pend) begin
            srv_icm <= icm_pend && (!dbg_pend || !last_icm);
            state   <= xdom_bus_pkg::ACCESS;
          end
        end
        xdom_bus_pkg::ACCESS: begin
          state <= xdom_bus_pkg::ACK;
        end
        xdom_bus_pkg::ACK: begin
          last_icm <= srv_icm;
          state    <= xdom_bus_pkg::IDLE;
        end
        default: begin
          state <= xdom_bus_pkg::IDLE;
        end
      endcase
    end
  end

  // Read word from whichever block decodes the address
  always_ff @(posedge clk) begin
    if (state == xdom_bus_pkg::ACCESS) begin
      if (i_wvb_hit) begin
        rd_q <= i_wvb_rd_data;
      end else if (i_io_hit) begin
        rd_q <= i_io_rd_data;
      end else begin
        rd_q <= '0;
      end
    end
  end

  always_comb begin
    o_bus.wr      = (state == xdom_bus_pkg::ACCESS) && srv_req.wr_req;
    o_bus.adr     = srv_req.adr;
    o_bus.wr_data = srv_req.wr_data;
    o_dbg.ack     = (state == xdom_bus_pkg::ACK) && !srv_icm;
    o_dbg.rd_data = rd_q;
    o_icm.ack     = (state == xdom_bus_pkg::ACK) && srv_icm;
    o_icm.rd_data = rd_q;
  end

endmodule

// File: src/io_ctrl_regs.sv
////////////////////
// ADC and discriminator I/O controls. Delay and bitslip pulses go to the
// selected channel only. Also the tap read-back and the ADC serial task.
////////////////////
`include "xdom_defines.svh"

module io_ctrl_regs (
  input  logic                                          clk,
  input  logic                                          rst,
  input  xdom_bus_pkg::reg_bus_t                        i_bus,
  input  logic [`XDOM_N_CHANNELS*`XDOM_TAP_W-1:0]       i_adc_delay_tap,
  input  logic                                          i_adc_spi_ack,
  input  logic [7:0]                                    i_adc_spi_rd_data,
  output xdom_bus_pkg::data_t                           o_rd_data,
  output logic                                          o_hit,
  output logic [2*`XDOM_N_CHANNELS-1:0]                 o_adc_delay_ce,
  output logic [2*`XDOM_N_CHANNELS-1:0]                 o_adc_delay_inc,
  output logic [2*`XDOM_N_CHANNELS-1:0]                 o_adc_bitslip,
  output xdom_reg_pkg::chan_mask_t                      o_discr_bitslip,
  output xdom_reg_pkg::chan_mask_t                      o_adc_io_reset,
  output xdom_reg_pkg::chan_mask_t                      o_discr_io_reset,
  output logic                                          o_adc_spi_req,
  output logic [5:0]                                    o_adc_spi_sel,
  output logic [23:0]                                   o_adc_spi_wr_data
);

  xdom_reg_pkg::chan_sel_t  io_sel;
  xdom_reg_pkg::io_pulse_t  pulse_q;
  xdom_reg_pkg::tap_t       tap_q;
  logic [2*`XDOM_N_CHANNELS-1:0] ce_d;
  logic [2*`XDOM_N_CHANNELS-1:0] inc_d;
  logic [2*`XDOM_N_CHANNELS-1:0] bitslip_d;
  xdom_reg_pkg::chan_mask_t discr_bitslip_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      io_sel            <= '0;
      pulse_q           <= '0;
      o_adc_io_reset    <= '1;
      o_discr_io_reset  <= '1;
      o_adc_spi_sel     <= '0;
      o_adc_spi_wr_data <= '0;
      o_adc_spi_req     <= 1'b0;
    end else begin
      pulse_q <= '0;
      // Request holds until the serial engine acknowledges
      if (i_adc_spi_ack) begin
        o_adc_spi_req <= 1'b0;
      end else if (i_bus.wr && i_bus.adr == `ADR_ADC_SPI_TASK && i_bus.wr_data[0]) begin
        o_adc_spi_req <= 1'b1;
      end
      if (i_bus.wr) begin
        case (i_bus.adr)
          `ADR_IO_SEL: io_sel <= i_bus.wr_data[4:0];
          `ADR_IO_PULSE: begin
            pulse_q.delay_inc     <= {i_bus.wr_data[4], i_bus.wr_data[0]};
            pulse_q.delay_ce      <= {i_bus.wr_data[5], i_bus.wr_data[1]};
            pulse_q.bitslip       <= {i_bus.wr_data[6], i_bus.wr_data[2]};
            pulse_q.discr_bitslip <= i_bus.wr_data[8];
          end
          `ADR_ADC_IORST_HI:   o_adc_io_reset[`XDOM_N_CHANNELS-1:16] <= i_bus.wr_data[7:0];
          `ADR_ADC_IORST_LO:   o_adc_io_reset[15:0] <= i_bus.wr_data;
          `ADR_DISCR_IORST_HI: o_discr_io_reset[`XDOM_N_CHANNELS-1:16] <= i_bus.wr_data[7:0];
          `ADR_DISCR_IORST_LO: o_discr_io_reset[15:0] <= i_bus.wr_data;
          `ADR_ADC_SPI_SEL:    o_adc_spi_sel <= i_bus.wr_data[5:0];
          `ADR_ADC_SPI_WD_HI:  o_adc_spi_wr_data[23:16] <= i_bus.wr_data[7:0];
          `ADR_ADC_SPI_WD_LO:  o_adc_spi_wr_data[15:0] <= i_bus.wr_data;
          default: begin
          end
        endcase
      end
    end
  end

  ////////////////////
  // Pulse demux to the selected channel
  for (genvar i = 0; i < `XDOM_N_CHANNELS; i++) begin : g_demux
    assign ce_d[2*i +: 2]      = (io_sel == 5'(i)) ? pulse_q.delay_ce : 2'b00;
    assign inc_d[2*i +: 2]     = (io_sel == 5'(i)) ? pulse_q.delay_inc : 2'b00;
    assign bitslip_d[2*i +: 2] = (io_sel == 5'(i)) ? pulse_q.bitslip : 2'b00;
    assign discr_bitslip_d[i]  = (io_sel == 5'(i)) && pulse_q.discr_bitslip;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_adc_delay_ce  <= '0;
      o_adc_delay_inc <= '0;
      o_adc_bitslip   <= '0;
      o_discr_bitslip <= '0;
    end else begin
      o_adc_delay_ce  <= ce_d;
      o_adc_delay_inc <= inc_d;
      o_adc_bitslip   <= bitslip_d;
      o_discr_bitslip <= discr_bitslip_d;
    end
  end

  // Tap of the selected channel
  always_ff @(posedge clk) begin
    tap_q <= i_adc_delay_tap[int'(io_sel)*`XDOM_TAP_W +: `XDOM_TAP_W];
  end

  ////////////////////
  // Read side
  always_comb begin
    o_hit     = 1'b1;
    o_rd_data = '0;
    case (i_bus.adr)
      `ADR_IO_SEL:         o_rd_data = {11'b0, io_sel};
      `ADR_IO_PULSE:       o_rd_data = '0;
      `ADR_TAP:            o_rd_data = {6'b0, tap_q};
      `ADR_ADC_IORST_HI:   o_rd_data = {8'b0, o_adc_io_reset[`XDOM_N_CHANNELS-1:16]};
      `ADR_ADC_IORST_LO:   o_rd_data = o_adc_io_reset[15:0];
      `ADR_DISCR_IORST_HI: o_rd_data = {8'b0, o_discr_io_reset[`XDOM_N_CHANNELS-1:16]};
      `ADR_DISCR_IORST_LO: o_rd_data = o_discr_io_reset[15:0];
      `ADR_ADC_SPI_SEL:    o_rd_data = {10'b0, o_adc_spi_sel};
      `ADR_ADC_SPI_TASK:   o_rd_data = {15'b0, o_adc_spi_req | i_adc_spi_ack};
      `ADR_ADC_SPI_WD_HI:  o_rd_data = {8'b0, o_adc_spi_wr_data[23:16]};
      `ADR_ADC_SPI_WD_LO:  o_rd_data = o_adc_spi_wr_data[15:0];
      `ADR_ADC_SPI_RD:     o_rd_data = {8'b0, i_adc_spi_rd_data};
      default:             o_hit = 1'b0;
    endcase
  end

endmodule

// File: src/wvb_cfg_regs.sv
////////////////////
// Trigger and waveform buffer configuration registers, one-shot arm and
// run per channel, armed status and version read-back
////////////////////
`include "xdom_defines.svh"

module wvb_cfg_regs (
  input  logic                     clk,
  input  logic                     rst,
  input  xdom_bus_pkg::reg_bus_t   i_bus,
  input  xdom_reg_pkg::chan_mask_t i_wvb_armed,
  output xdom_bus_pkg::data_t      o_rd_data,
  output logic                     o_hit,
  output xdom_reg_pkg::trig_conf_t o_trig_bundle,
  output xdom_reg_pkg::wvb_conf_t  o_wvb_conf,
  output xdom_reg_pkg::chan_mask_t o_trig_run,
  output xdom_reg_pkg::chan_mask_t o_wvb_arm
);

  ////////////////////
  // Write side
  always_ff @(posedge clk) begin
    if (rst) begin
      o_trig_bundle <= '0;
      o_wvb_conf    <= '0;
      o_trig_run    <= '0;
      o_wvb_arm     <= '0;
    end else begin
      // One-shots
      o_trig_run <= '0;
      o_wvb_arm  <= '0;
      if (i_bus.wr) begin
        case (i_bus.adr)
          `ADR_TRIG_CTRL: begin
            o_trig_bundle.trig_et   <= i_bus.wr_data[0];
            o_trig_bundle.trig_gt   <= i_bus.wr_data[1];
            o_trig_bundle.trig_lt   <= i_bus.wr_data[2];
            o_trig_bundle.discr_pol <= i_bus.wr_data[3];
            o_trig_bundle.discr_en  <= i_bus.wr_data[4];
            o_trig_bundle.thresh_en <= i_bus.wr_data[5];
            o_trig_bundle.ext_en    <= i_bus.wr_data[6];
          end
          `ADR_TRIG_THR:    o_trig_bundle.thresh <= i_bus.wr_data[11:0];
          `ADR_TRIG_RUN_LO: o_trig_run[15:0] <= i_bus.wr_data;
          `ADR_TRIG_RUN_HI: o_trig_run[`XDOM_N_CHANNELS-1:16] <= i_bus.wr_data[7:0];
          `ADR_TRIG_MODE:   o_wvb_conf.trig_mode <= i_bus.wr_data[0];
          `ADR_ARM_LO:      o_wvb_arm[15:0] <= i_bus.wr_data;
          `ADR_ARM_HI:      o_wvb_arm[`XDOM_N_CHANNELS-1:16] <= i_bus.wr_data[7:0];
          `ADR_CNST_RUN:    o_wvb_conf.cnst_run <= i_bus.wr_data[0];
          `ADR_CNST_CONF:   o_wvb_conf.cnst_conf <= i_bus.wr_data[11:0];
          `ADR_TEST_CONF:   o_wvb_conf.test_conf <= i_bus.wr_data[11:0];
          `ADR_POST_CONF:   o_wvb_conf.post_conf <= i_bus.wr_data[7:0];
          `ADR_PRE_CONF:    o_wvb_conf.pre_conf <= i_bus.wr_data[4:0];
          default: begin
          end
        endcase
      end
    end
  end

  ////////////////////
  // Read side, one-shots read as zero
  always_comb begin
    o_hit     = 1'b1;
    o_rd_data = '0;
    case (i_bus.adr)
      `ADR_VERSION:     o_rd_data = `XDOM_VERSION;
      `ADR_TRIG_CTRL:   o_rd_data = {9'b0, o_trig_bundle.ext_en, o_trig_bundle.thresh_en,
                                     o_trig_bundle.discr_en, o_trig_bundle.discr_pol,
                                     o_trig_bundle.trig_lt, o_trig_bundle.trig_gt,
                                     o_trig_bundle.trig_et};
      `ADR_TRIG_THR:    o_rd_data = {4'b0, o_trig_bundle.thresh};
      `ADR_TRIG_RUN_LO, `ADR_TRIG_RUN_HI, `ADR_ARM_LO, `ADR_ARM_HI: o_rd_data = '0;
      `ADR_TRIG_MODE:   o_rd_data = {15'b0, o_wvb_conf.trig_mode};
      `ADR_ARMED_LO:    o_rd_data = i_wvb_armed[15:0];
      `ADR_ARMED_HI:    o_rd_data = {8'b0, i_wvb_armed[`XDOM_N_CHANNELS-1:16]};
      `ADR_CNST_RUN:    o_rd_data = {15'b0, o_wvb_conf.cnst_run};
      `ADR_CNST_CONF:   o_rd_data = {4'b0, o_wvb_conf.cnst_conf};
      `ADR_TEST_CONF:   o_rd_data = {4'b0, o_wvb_conf.test_conf};
      `ADR_POST_CONF:   o_rd_data = {8'b0, o_wvb_conf.post_conf};
      `ADR_PRE_CONF:    o_rd_data = {11'b0, o_wvb_conf.pre_conf};
      default:          o_hit = 1'b0;
    endcase
  end

endmodule

// File: src/xdom_bus_pkg.sv
////////////////////
// Command port and register bus types, shared by the arbiter and the
// register blocks
////////////////////
`include "xdom_defines.svh"

package xdom_bus_pkg;

  typedef logic [`XDOM_ADR_W-1:0]  adr_t;
  typedef logic [`XDOM_DATA_W-1:0] data_t;

  // Request from a command port
  typedef struct packed {
    logic  wr_req;
    logic  rd_req;
    adr_t  adr;
    data_t wr_data;
  } cmd_req_t;

  // Response to a command port, rd_data valid with ack
  typedef struct packed {
    logic  ack;
    data_t rd_data;
  } cmd_rsp_t;

  // Shared register bus
  typedef struct packed {
    logic  wr;
    adr_t  adr;
    data_t wr_data;
  } reg_bus_t;

  typedef enum logic [1:0] {IDLE, ACCESS, ACK} arb_state_t;

endpackage

// File: src/xdom_ctrl.sv
////////////////////
// Control register core. Two command ports share one register bus
// through the arbiter, with two register blocks behind it.
////////////////////
`include "xdom_defines.svh"

module xdom_ctrl (
  input  logic                                    clk,
  input  logic                                    rst,
  input  xdom_bus_pkg::cmd_req_t                  i_dbg,
  input  xdom_bus_pkg::cmd_req_t                  i_icm,
  output xdom_bus_pkg::cmd_rsp_t                  o_dbg,
  output xdom_bus_pkg::cmd_rsp_t                  o_icm,
  input  xdom_reg_pkg::chan_mask_t                i_wvb_armed,
  input  logic [`XDOM_N_CHANNELS*`XDOM_TAP_W-1:0] i_adc_delay_tap,
  input  logic                                    i_adc_spi_ack,
  input  logic [7:0]                              i_adc_spi_rd_data,
  output xdom_reg_pkg::trig_conf_t                o_trig_bundle,
  output xdom_reg_pkg::wvb_conf_t                 o_wvb_conf,
  output xdom_reg_pkg::chan_mask_t                o_trig_run,
  output xdom_reg_pkg::chan_mask_t                o_wvb_arm,
  output logic [2*`XDOM_N_CHANNELS-1:0]           o_adc_delay_ce,
  output logic [2*`XDOM_N_CHANNELS-1:0]           o_adc_delay_inc,
  output logic [2*`XDOM_N_CHANNELS-1:0]           o_adc_bitslip,
  output xdom_reg_pkg::chan_mask_t                o_discr_bitslip,
  output xdom_reg_pkg::chan_mask_t                o_adc_io_reset,
  output xdom_reg_pkg::chan_mask_t                o_discr_io_reset,
  output logic                                    o_adc_spi_req,
  output logic [5:0]                              o_adc_spi_sel,
  output logic [23:0]                             o_adc_spi_wr_data
);

  xdom_bus_pkg::reg_bus_t reg_bus;
  xdom_bus_pkg::data_t    wvb_rd_data;
  xdom_bus_pkg::data_t    io_rd_data;
  logic                   wvb_hit;
  logic                   io_hit;

  cmd_arbiter u_arbiter (
    .clk(clk), .rst(rst),
    .i_dbg(i_dbg), .i_icm(i_icm), .o_dbg(o_dbg), .o_icm(o_icm),
    .o_bus(reg_bus),
    .i_wvb_rd_data(wvb_rd_data), .i_wvb_hit(wvb_hit),
    .i_io_rd_data(io_rd_data), .i_io_hit(io_hit)
  );

  wvb_cfg_regs u_wvb_regs (
    .clk(clk), .rst(rst), .i_bus(reg_bus), .i_wvb_armed(i_wvb_armed),
    .o_rd_data(wvb_rd_data), .o_hit(wvb_hit),
    .o_trig_bundle(o_trig_bundle), .o_wvb_conf(o_wvb_conf),
    .o_trig_run(o_trig_run), .o_wvb_arm(o_wvb_arm)
  );

  io_ctrl_regs u_io_regs (
    .clk(clk), .rst(rst), .i_bus(reg_bus), .i_adc_delay_tap(i_adc_delay_tap),
    .i_adc_spi_ack(i_adc_spi_ack), .i_adc_spi_rd_data(i_adc_spi_rd_data),
    .o_rd_data(io_rd_data), .o_hit(io_hit),
    .o_adc_delay_ce(o_adc_delay_ce), .o_adc_delay_inc(o_adc_delay_inc),
    .o_adc_bitslip(o_adc_bitslip), .o_discr_bitslip(o_discr_bitslip),
    .o_adc_io_reset(o_adc_io_reset), .o_discr_io_reset(o_discr_io_reset),
    .o_adc_spi_req(o_adc_spi_req), .o_adc_spi_sel(o_adc_spi_sel),
    .o_adc_spi_wr_data(o_adc_spi_wr_data)
  );

endmodule

// File: src/xdom_defines.svh
////////////////////
// Shared sizes, version and register addresses of the readout controller.
// Include wherever a width or a register address is needed.
////////////////////
`ifndef XDOM_DEFINES_SVH
`define XDOM_DEFINES_SVH

`define XDOM_N_CHANNELS 24
`define XDOM_ADR_W      12
`define XDOM_DATA_W     16
`define XDOM_TAP_W      10
`define XDOM_VERSION    16'h0102

// Waveform / trigger block
`define ADR_VERSION        12'hFFF
`define ADR_TRIG_CTRL      12'hFFE
`define ADR_TRIG_THR       12'hFFD
`define ADR_TRIG_RUN_LO    12'hFFC
`define ADR_TRIG_MODE      12'hFFB
`define ADR_ARM_LO         12'hFFA
`define ADR_ARMED_LO       12'hFF9
`define ADR_CNST_RUN       12'hFF8
`define ADR_CNST_CONF      12'hFF7
`define ADR_TEST_CONF      12'hFF6
`define ADR_POST_CONF      12'hFF5
`define ADR_PRE_CONF       12'hFF4
`define ADR_TRIG_RUN_HI    12'hEF4
`define ADR_ARM_HI         12'hEF3
`define ADR_ARMED_HI       12'hEF2

// I/O control block
`define ADR_IO_SEL         12'hEEE
`define ADR_IO_PULSE       12'hEED
`define ADR_TAP            12'hEEC
`define ADR_ADC_IORST_HI   12'hEEB
`define ADR_ADC_IORST_LO   12'hEEA
`define ADR_DISCR_IORST_HI 12'hEE7
`define ADR_DISCR_IORST_LO 12'hEE6
`define ADR_ADC_SPI_SEL    12'hEE4
`define ADR_ADC_SPI_TASK   12'hEE3
`define ADR_ADC_SPI_WD_HI  12'hEE2
`define ADR_ADC_SPI_WD_LO  12'hEE1
`define ADR_ADC_SPI_RD     12'hEE0

`endif

// File: src/xdom_reg_pkg.sv
////////////////////
// Register field types of the waveform/trigger and I/O control blocks
////////////////////
`include "xdom_defines.svh"

package xdom_reg_pkg;

  typedef logic [`XDOM_N_CHANNELS-1:0] chan_mask_t;
  typedef logic [4:0]                  chan_sel_t;
  typedef logic [`XDOM_TAP_W-1:0]      tap_t;

  // Trigger configuration bundle
  typedef struct packed {
    logic        trig_et;
    logic        trig_gt;
    logic        trig_lt;
    logic        run;
    logic        discr_pol;
    logic [11:0] thresh;
    logic        discr_en;
    logic        thresh_en;
    logic        ext_en;
  } trig_conf_t;

  // Waveform buffer configuration bundle
  typedef struct packed {
    logic [11:0] cnst_conf;
    logic [11:0] test_conf;
    logic [7:0]  post_conf;
    logic [4:0]  pre_conf;
    logic        arm;
    logic        trig_mode;
    logic        cnst_run;
  } wvb_conf_t;

  // One-shot I/O pulse field, index is the lane
  typedef struct packed {
    logic       discr_bitslip;
    logic [1:0] bitslip;
    logic [1:0] delay_ce;
    logic [1:0] delay_inc;
  } io_pulse_t;

endpackage

// File: xdom_ctrl.f
+incdir+src
src/xdom_bus_pkg.sv
src/xdom_reg_pkg.sv
src/cmd_arbiter.sv
src/wvb_cfg_regs.sv
src/io_ctrl_regs.sv
src/xdom_ctrl.sv
bench/tb_clkgen.sv
bench/xdom_ctrl_tb.sv
